//--- Makefile
# Verilator build and run of the memory test chip testbench

VERILATOR ?= verilator
TOP       ?= tb_testchip
LOG       ?= sim.log
VFLAGS    ?= --x-initial unique
OBJ_DIR   ?= obj_dir
FILELIST  := sim.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) LOG=$(LOG) VFLAGS=$(VFLAGS)"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "No result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
verilog/testchip_pkg.sv
verilog/sram_pkg.sv
verilog/packet_deserializer.sv
verilog/testchip_ctrl.sv
verilog/sram_1rw_model.sv
verilog/result_serializer.sv
verilog/testchip_top.sv
sim/tb_testchip.sv

//--- sim/tb_testchip.sv
`timescale 1ns/100ps
`default_nettype none

module tb_testchip;

    localparam int A_DEPTH = 256;
    localparam int B_DEPTH = 512;
    // Commands per test
    localparam int N_T1   = 200;
    localparam int N_T2   = 200;
    localparam int N_T3   = 8;
    localparam int N_T4   = 30;
    localparam int N_T5   = 16;
    localparam int N_CMDS = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;

    // Model word holding data and one known flag per byte lane
    typedef struct packed {
        logic [7:0]  known;
        logic [63:0] data;
    } model_word_t;

    // Expected read response and the edge that sampled its strobe
    typedef struct packed {
        testchip_pkg::rsp_t rsp;
        logic [63:0]        known_bits;
        logic [31:0]        edge_no;
        logic               timed;
    } exp_rsp_t;

    logic               clk_i;
    logic               rst_n_i;
    logic               in_select_i;
    testchip_pkg::cmd_t la_cmd_i;
    logic               la_cmd_valid_i;
    logic               gpio_packet_i;
    testchip_pkg::rsp_t la_rsp_o;
    logic               la_rsp_valid_o;
    logic               gpio_data_o;

    // Reference memories keyed by wrapped address
    model_word_t        mem_a [int];
    model_word_t        mem_b [int];
    exp_rsp_t           exp_q [$];
    // Expected rdata waiting for its serial copy
    logic [63:0]        ser_exp_q [$];

    logic [31:0]        rng_q = 32'd44;
    logic [31:0]        edge_cnt = 32'd0;
    logic               ser_check_en = 1'b0;
    testchip_pkg::cmd_t tmp_cmd;
    string              test_name;
    int                 err_cnt = 0;
    int                 chk_cnt = 0;
    int                 err_at_start = 0;
    int                 tests_run = 0;

    testchip_top #(
        .BANK_A_DEPTH (A_DEPTH),
        .BANK_B_DEPTH (B_DEPTH)
    ) i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_select_i    (in_select_i),
        .la_cmd_i       (la_cmd_i),
        .la_cmd_valid_i (la_cmd_valid_i),
        .gpio_packet_i  (gpio_packet_i),
        .la_rsp_o       (la_rsp_o),
        .la_rsp_valid_o (la_rsp_valid_o),
        .gpio_data_o    (gpio_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Edge count for the response latency
    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 32'd1;
    end

    // Budget of 100 cycles per command plus margin
    initial begin
        repeat (N_CMDS * 100 + 2000) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles", N_CMDS * 100 + 2000);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    function automatic testchip_pkg::bank_e random_bank();
        logic [31:0] r;
        r = next_random();
        return testchip_pkg::bank_e'(r[4]);
    endfunction

    // Few distinct addresses so reads hit written words
    // Bit 8 exercises the wrap
    function automatic testchip_pkg::cmd_t random_cmd(input testchip_pkg::bank_e bank);
        testchip_pkg::cmd_t c;
        logic [31:0]        r;
        r       = next_random();
        c.write = r[0];
        c.bank  = bank;
        c.addr  = r[17:9] & 9'h10f;
        c.wmask = r[31:24];
        c.wdata = {next_random(), next_random()};
        return c;
    endfunction

    // Byte flags widened to a bit mask
    function automatic logic [63:0] byte_bits(input logic [7:0] m);
        logic [63:0] bits;
        for (int b = 0; b < 8; b++) begin
            bits[b*8 +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    function automatic int wrap_addr(input testchip_pkg::bank_e bank, input logic [8:0] a);
        return (bank == testchip_pkg::BANK_A) ? int'(a) % A_DEPTH : int'(a) % B_DEPTH;
    endfunction

    // Writes update the model and reads queue the expected response
    task automatic model_apply(input testchip_pkg::cmd_t c, input logic [31:0] edge_no,
                               input logic timed);
        model_word_t ent;
        exp_rsp_t    e;
        int          key;
        logic [7:0]  lanes;
        key = wrap_addr(c.bank, c.addr);
        if (c.bank == testchip_pkg::BANK_A) begin
            ent   = mem_a.exists(key) ? mem_a[key] : '0;
            lanes = 8'h0f;
        end else begin
            ent   = mem_b.exists(key) ? mem_b[key] : '0;
            lanes = 8'hff;
        end
        if (c.write) begin
            for (int b = 0; b < 8; b++) begin
                if (lanes[b] && c.wmask[b]) begin
                    ent.data[b*8 +: 8] = c.wdata[b*8 +: 8];
                    ent.known[b]       = 1'b1;
                end
            end
            if (c.bank == testchip_pkg::BANK_A) begin
                mem_a[key] = ent;
            end else begin
                mem_b[key] = ent;
            end
        end else begin
            e.rsp.bank   = c.bank;
            e.rsp.addr   = 9'(key);
            e.rsp.rdata  = ent.data & byte_bits(lanes);
            // Unused bank A lanes are known zero
            // Unwritten bytes are skipped
            e.known_bits = byte_bits(ent.known | ~lanes);
            e.edge_no    = edge_no;
            e.timed      = timed;
            exp_q.push_back(e);
        end
    endtask

    // One-cycle strobe on the LA bus
    task automatic send_parallel(input testchip_pkg::cmd_t c);
        la_cmd_i       = c;
        la_cmd_valid_i = 1'b1;
        if (!in_select_i) begin
            model_apply(c, edge_cnt + 32'd1, 1'b1);
        end
        @(negedge clk_i);
        la_cmd_valid_i = 1'b0;
    endtask

    // Start bit then the packet MSB first then one idle cycle
    task automatic send_serial(input testchip_pkg::cmd_t c);
        gpio_packet_i = 1'b1;
        for (int i = testchip_pkg::CMD_BITS - 1; i >= 0; i--) begin
            @(negedge clk_i);
            gpio_packet_i = c[i];
        end
        @(negedge clk_i);
        gpio_packet_i = 1'b0;
        if (in_select_i) begin
            model_apply(c, 32'd0, 1'b0);
        end
        @(negedge clk_i);
    endtask

    task automatic check_response();
        exp_rsp_t    e;
        logic [31:0] lat;
        chk_cnt++;
        assert (exp_q.size() != 0) else begin
            $display("%s: a read response came out with no read outstanding", test_name);
            err_cnt++;
        end
        if (exp_q.size() != 0) begin
            e   = exp_q.pop_front();
            lat = edge_cnt + 32'd1 - e.edge_no;
            assert (la_rsp_o.bank == e.rsp.bank && la_rsp_o.addr == e.rsp.addr) else begin
                $display("Fail %s: bank/addr expected %0d/%h actual %0d/%h", test_name,
                         e.rsp.bank, e.rsp.addr, la_rsp_o.bank, la_rsp_o.addr);
                err_cnt++;
            end
            assert ((la_rsp_o.rdata & e.known_bits) == (e.rsp.rdata & e.known_bits)) else begin
                $display("Fail %s: rdata expected %h actual %h (known mask %h)", test_name,
                         e.rsp.rdata, la_rsp_o.rdata, e.known_bits);
                err_cnt++;
            end
            assert (!e.timed || lat == 32'd3) else begin
                $display("Fail %s: latency expected 3 actual %0d", test_name, lat);
                err_cnt++;
            end
            if (ser_check_en) begin
                ser_exp_q.push_back(e.rsp.rdata);
            end
        end
    endtask

    // Outputs sampled away from the rising edge
    always @(negedge clk_i) begin
        if (rst_n_i && la_rsp_valid_o) begin
            check_response();
        end
    end

    // GPIO result frame decoder that stays in step with the serializer
    initial begin : decode_serial
        logic [63:0] bits;
        logic [63:0] want;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && gpio_data_o) begin
                for (int i = 0; i < 64; i++) begin
                    @(negedge clk_i);
                    bits = {bits[62:0], gpio_data_o};
                end
                if (ser_check_en) begin
                    chk_cnt++;
                    assert (ser_exp_q.size() != 0) else begin
                        $display("%s: a serial frame came out with no parallel response",
                                 test_name);
                        err_cnt++;
                    end
                    if (ser_exp_q.size() != 0) begin
                        want = ser_exp_q.pop_front();
                        assert (bits == want) else begin
                            $display("Fail %s: serial rdata expected %h actual %h",
                                     test_name, want, bits);
                            err_cnt++;
                        end
                    end
                end
            end
        end
    end

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (8) @(negedge clk_i);
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        wait_idle();
        tests_run++;
        if (err_cnt == err_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, err_cnt - err_at_start);
        end
    endtask

    initial begin
        rst_n_i        = 1'b0;
        in_select_i    = 1'b0;
        la_cmd_i       = '0;
        la_cmd_valid_i = 1'b0;
        gpio_packet_i  = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk_i);

        // Random gaps of up to two cycles
        begin_test("parallel bank A");
        for (int i = 0; i < N_T1; i++) begin
            send_parallel(random_cmd(testchip_pkg::BANK_A));
            repeat (int'(next_random() % 32'd3)) @(negedge clk_i);
        end
        end_test();

        // A command every cycle
        begin_test("parallel bank B back to back");
        for (int i = 0; i < N_T2; i++) begin
            send_parallel(random_cmd(testchip_pkg::BANK_B));
        end
        end_test();

        // Full word write and two ignored overwrites before a read
        begin_test("source selection");
        for (int i = 0; i < N_T3 / 4; i++) begin
            tmp_cmd       = random_cmd(testchip_pkg::bank_e'(i[0]));
            tmp_cmd.write = 1'b1;
            tmp_cmd.wmask = 8'hff;
            send_parallel(tmp_cmd);
            tmp_cmd.wdata = ~tmp_cmd.wdata;
            in_select_i   = 1'b1;
            send_parallel(tmp_cmd);
            in_select_i   = 1'b0;
            send_serial(tmp_cmd);
            tmp_cmd.write = 1'b0;
            send_parallel(tmp_cmd);
        end
        end_test();

        begin_test("serial command input");
        in_select_i = 1'b1;
        for (int i = 0; i < N_T4; i++) begin
            send_serial(random_cmd(random_bank()));
        end
        wait_idle();
        in_select_i = 1'b0;
        end_test();

        // Let any frame still on the GPIO line finish first
        begin_test("serial result output");
        repeat (80) @(negedge clk_i);
        ser_check_en = 1'b1;
        for (int i = 0; i < N_T5 / 2; i++) begin
            tmp_cmd       = random_cmd(random_bank());
            tmp_cmd.write = 1'b1;
            // Full mask so every byte of the read back word is known
            tmp_cmd.wmask = 8'hff;
            send_parallel(tmp_cmd);
            tmp_cmd.write = 1'b0;
            send_parallel(tmp_cmd);
            repeat (75) @(negedge clk_i);
        end
        wait_idle();
        chk_cnt++;
        assert (ser_exp_q.size() == 0) else begin
            $display("%s: %0d read results never came out on the GPIO pin", test_name,
                     ser_exp_q.size());
            err_cnt++;
        end
        ser_check_en = 1'b0;
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/packet_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

module packet_deserializer (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 serial_i,
    output testchip_pkg::cmd_t  cmd_o,
    output logic                cmd_valid_o
);

    localparam int NBITS = testchip_pkg::CMD_BITS;
    localparam int CW    = $clog2(NBITS);

    typedef enum logic {
        S_IDLE,
        S_SHIFT
    } state_e;

    state_e           state_q;
    logic [CW-1:0]    cnt_q;
    // Payload shift register, MSB arrives first
    logic [NBITS-1:0] shift_q;

    // Control path: start detect, bit count, valid pulse
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            cnt_q       <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    // Line idles low, a single high sample opens a frame
                    if (serial_i) begin
                        state_q <= S_SHIFT;
                        cnt_q   <= '0;
                    end
                end
                S_SHIFT: begin
                    cnt_q <= cnt_q + 1'b1;
                    // Last payload bit sampled on this edge
                    if (cnt_q == CW'(NBITS - 1)) begin
                        cmd_valid_o <= 1'b1;
                        state_q     <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Shift only while a frame is being received
    always_ff @(posedge clk_i) begin
        if (state_q == S_SHIFT) begin
            shift_q <= {shift_q[NBITS-2:0], serial_i};
        end
    end

    // Register holds the packet until the next frame starts shifting
    assign cmd_o = testchip_pkg::cmd_t'(shift_q);

endmodule

`default_nettype wire

//--- verilog/result_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module result_serializer (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  testchip_pkg::rsp_t rsp_i,
    input  wire                rsp_valid_i,
    output logic               serial_o
);

    typedef enum logic {
        S_IDLE,
        S_SEND
    } state_e;

    state_e      state_q;
    // Data bit counter, 64 bits per frame
    logic [5:0]  cnt_q;
    logic [63:0] shift_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= S_IDLE;
            cnt_q    <= '0;
            serial_o <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    // Start bit goes out the cycle after the strobe
                    serial_o <= rsp_valid_i;
                    if (rsp_valid_i) begin
                        state_q <= S_SEND;
                        cnt_q   <= '0;
                    end
                end
                S_SEND: begin
                    // MSB first
                    serial_o <= shift_q[63];
                    cnt_q    <= cnt_q + 1'b1;
                    if (cnt_q == 6'd63) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Responses arriving mid-frame are dropped here
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && rsp_valid_i) begin
            shift_q <= rsp_i.rdata;
        end else if (state_q == S_SEND) begin
            shift_q <= {shift_q[62:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- verilog/sram_1rw_model.sv
`timescale 1ns/100ps
`default_nettype none

module sram_1rw_model #(
    parameter int  DEPTH  = 256,
    // Request struct with en, we, wmask, addr and wdata fields
    parameter type req_t  = sram_pkg::sram32_req_t,
    parameter type word_t = logic [31:0]
) (
    input  wire   clk_i,
    input  req_t  req_i,
    output word_t rdata_o
);

    localparam int AW     = $clog2(DEPTH);
    localparam int NBYTES = $bits(word_t) / 8;

    word_t         mem [DEPTH];
    logic [AW-1:0] idx;

    // Out of range addresses fold back into the array
    assign idx = AW'(req_i.addr % DEPTH);

    // Single port, either write or read per enabled cycle
    always_ff @(posedge clk_i) begin
        if (req_i.en) begin
            if (req_i.we) begin
                // Byte lanes without a mask bit keep their contents
                for (int b = 0; b < NBYTES; b++) begin
                    if (req_i.wmask[b]) begin
                        mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                // Read data is held until the next read
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sram_pkg.sv
`default_nettype none

package sram_pkg;

    // Single-port request for the 32x256 bank
    typedef struct packed {
        // Chip enable, one cycle per access
        logic        en;
        // Write enable, read when low
        logic        we;
        logic [3:0]  wmask;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } sram32_req_t;

    // Single-port request for the 64x512 bank
    typedef struct packed {
        logic        en;
        logic        we;
        logic [7:0]  wmask;
        logic [8:0]  addr;
        logic [63:0] wdata;
    } sram64_req_t;

endpackage

`default_nettype wire

//--- verilog/testchip_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module testchip_ctrl (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    // Low selects the LA bus, high the serial deserializer
    input  wire                       in_select_i,
    input  testchip_pkg::cmd_t        la_cmd_i,
    input  wire                       la_cmd_valid_i,
    input  testchip_pkg::cmd_t        ser_cmd_i,
    input  wire                       ser_cmd_valid_i,
    output sram_pkg::sram32_req_t     bank_a_req_o,
    output sram_pkg::sram64_req_t     bank_b_req_o,
    input  wire [31:0]                bank_a_rdata_i,
    input  wire [63:0]                bank_b_rdata_i,
    output testchip_pkg::rsp_t        rsp_o,
    output logic                      rsp_valid_o
);

    // Bank and address of a read in flight
    typedef struct packed {
        testchip_pkg::bank_e bank;
        logic [8:0]          addr;
    } tag_t;

    logic               sel_valid;
    testchip_pkg::cmd_t sel_cmd;
    logic               sel_is_a;
    tag_t               sel_tag;

    // Registered command payload feeding both bank requests
    testchip_pkg::cmd_t cmd_q;
    logic               a_en_q;
    logic               b_en_q;

    // Two-stage tag pipeline, one stage per edge until rdata is ready
    tag_t               tag_q [2];
    logic [1:0]         tag_vld_q;

    // Only the selected source is looked at
    assign sel_valid = in_select_i ? ser_cmd_valid_i : la_cmd_valid_i;
    assign sel_cmd   = in_select_i ? ser_cmd_i : la_cmd_i;
    assign sel_is_a  = (sel_cmd.bank == testchip_pkg::BANK_A);

    // Bank A is 256 deep, so its address wraps at 8 bits
    assign sel_tag.bank = sel_cmd.bank;
    assign sel_tag.addr = sel_is_a ? {1'b0, sel_cmd.addr[7:0]} : sel_cmd.addr;

    // Enables and tag valids
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_en_q      <= 1'b0;
            b_en_q      <= 1'b0;
            tag_vld_q   <= 2'b00;
            rsp_valid_o <= 1'b0;
        end else begin
            // Exactly one cycle of enable on the target bank
            a_en_q      <= sel_valid && sel_is_a;
            b_en_q      <= sel_valid && !sel_is_a;
            tag_vld_q   <= {tag_vld_q[0], sel_valid && !sel_cmd.write};
            // Data from the bank is registered one edge after its access
            rsp_valid_o <= tag_vld_q[1];
        end
    end

    // Payload registers, loaded only when something happens
    always_ff @(posedge clk_i) begin
        if (sel_valid) begin
            cmd_q <= sel_cmd;
        end
        if (sel_valid && !sel_cmd.write) begin
            tag_q[0] <= sel_tag;
        end
        if (tag_vld_q[0]) begin
            tag_q[1] <= tag_q[0];
        end
        if (tag_vld_q[1]) begin
            rsp_o.bank <= tag_q[1].bank;
            rsp_o.addr <= tag_q[1].addr;
            // Narrow bank data is zero-extended to the full width
            if (tag_q[1].bank == testchip_pkg::BANK_A) begin
                rsp_o.rdata <= {32'b0, bank_a_rdata_i};
            end else begin
                rsp_o.rdata <= bank_b_rdata_i;
            end
        end
    end

    // Narrowed requests, upper bits simply dropped for bank A
    assign bank_a_req_o = '{
        en:    a_en_q,
        we:    cmd_q.write,
        wmask: cmd_q.wmask[3:0],
        addr:  cmd_q.addr[7:0],
        wdata: cmd_q.wdata[31:0]
    };

    assign bank_b_req_o = '{
        en:    b_en_q,
        we:    cmd_q.write,
        wmask: cmd_q.wmask,
        addr:  cmd_q.addr,
        wdata: cmd_q.wdata
    };

endmodule

`default_nettype wire

//--- verilog/testchip_pkg.sv
`default_nettype none

package testchip_pkg;

    // Target bank of a test packet
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_e;

    // Command packet as seen on the LA bus and in a serial frame
    // Bank A only looks at the low 8 address, 4 mask and 32 data bits
    typedef struct packed {
        // High for a write, low for a read
        logic        write;
        bank_e       bank;
        logic [8:0]  addr;
        // One enable per byte lane
        logic [7:0]  wmask;
        logic [63:0] wdata;
    } cmd_t;

    // Packet length in bits, also the serial frame payload length
    localparam int CMD_BITS = $bits(cmd_t);

    // Read response returned on the LA bus
    typedef struct packed {
        bank_e       bank;
        // Address after wrapping to the bank depth
        logic [8:0]  addr;
        // Bank A data sits in the low half, upper half zero
        logic [63:0] rdata;
    } rsp_t;

endpackage

`default_nettype wire

//--- verilog/testchip_top.sv
`timescale 1ns/100ps
`default_nettype none

module testchip_top #(
    parameter int BANK_A_DEPTH = 256,
    parameter int BANK_B_DEPTH = 512
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    // Low picks the LA bus, high the GPIO serial input
    input  wire                in_select_i,
    input  testchip_pkg::cmd_t la_cmd_i,
    input  wire                la_cmd_valid_i,
    input  wire                gpio_packet_i,
    output testchip_pkg::rsp_t la_rsp_o,
    output logic               la_rsp_valid_o,
    output logic               gpio_data_o
);

    // Packet from the serial path
    testchip_pkg::cmd_t    ser_cmd;
    logic                  ser_cmd_valid;

    // Bank interfaces
    sram_pkg::sram32_req_t bank_a_req;
    sram_pkg::sram64_req_t bank_b_req;
    logic [31:0]           bank_a_rdata;
    logic [63:0]           bank_b_rdata;

    packet_deserializer i_deser (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .serial_i    (gpio_packet_i),
        .cmd_o       (ser_cmd),
        .cmd_valid_o (ser_cmd_valid)
    );

    testchip_ctrl i_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .in_select_i     (in_select_i),
        .la_cmd_i        (la_cmd_i),
        .la_cmd_valid_i  (la_cmd_valid_i),
        .ser_cmd_i       (ser_cmd),
        .ser_cmd_valid_i (ser_cmd_valid),
        .bank_a_req_o    (bank_a_req),
        .bank_b_req_o    (bank_b_req),
        .bank_a_rdata_i  (bank_a_rdata),
        .bank_b_rdata_i  (bank_b_rdata),
        .rsp_o           (la_rsp_o),
        .rsp_valid_o     (la_rsp_valid_o)
    );

    // Bank A, 32-bit words
    sram_1rw_model #(
        .DEPTH  (BANK_A_DEPTH),
        .req_t  (sram_pkg::sram32_req_t),
        .word_t (logic [31:0])
    ) i_bank_a (
        .clk_i   (clk_i),
        .req_i   (bank_a_req),
        .rdata_o (bank_a_rdata)
    );

    // Bank B, 64-bit words
    sram_1rw_model #(
        .DEPTH  (BANK_B_DEPTH),
        .req_t  (sram_pkg::sram64_req_t),
        .word_t (logic [63:0])
    ) i_bank_b (
        .clk_i   (clk_i),
        .req_i   (bank_b_req),
        .rdata_o (bank_b_rdata)
    );

    // Serial copy of each read result
    result_serializer i_ser (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rsp_i       (la_rsp_o),
        .rsp_valid_i (la_rsp_valid_o),
        .serial_o    (gpio_data_o)
    );

endmodule

`default_nettype wire
